//--- hw/lsu_op_pkg.sv
package lsu_op_pkg;

  // load function, RV32 funct3 encoding
  typedef enum logic [2:0] {
    LD_B  = 3'b000,
    LD_H  = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } ld_func_e;

  // store function, RV32 funct3 encoding
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } st_func_e;

  // core-side load request
  typedef struct packed {
    logic [31:0] addr;
    ld_func_e    func;
  } load_req_t;

  // core-side store request, data is right-aligned as in a register
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    st_func_e    func;
  } store_req_t;

endpackage

//--- hw/axi_pkg.sv
package axi_pkg;

  // transfer size codes, bytes = 2**size
  localparam logic [2:0] AXI_SIZE_B = 3'b000;
  localparam logic [2:0] AXI_SIZE_H = 3'b001;
  localparam logic [2:0] AXI_SIZE_W = 3'b010;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // read address and read data
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_ar_t;

  typedef struct packed {
    logic [63:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  // write address, write data and write response
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
  } axi_aw_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  // master to slave, read side
  typedef struct packed {
    axi_ar_t ar;
    logic    arvalid;
    logic    rready;
  } axi_rd_req_t;

  // slave to master, read side
  typedef struct packed {
    axi_r_t r;
    logic   arready;
    logic   rvalid;
  } axi_rd_rsp_t;

  // master to slave, write side
  typedef struct packed {
    axi_aw_t aw;
    logic    awvalid;
    axi_w_t  w;
    logic    wvalid;
    logic    bready;
  } axi_wr_req_t;

  // slave to master, write side
  typedef struct packed {
    axi_b_t b;
    logic   awready;
    logic   wready;
    logic   bvalid;
  } axi_wr_rsp_t;

endpackage

//--- hw/lsu.sv
`timescale 1ns/1ps

module lsu (
  input  logic                    clk,
  input  logic                    rstn,
  input  lsu_op_pkg::load_req_t   load_req,
  input  logic                    load_valid,
  output logic                    load_ready,
  output logic [31:0]             load_data,
  output logic                    load_rsp_valid,
  input  logic                    load_rsp_ready,
  input  lsu_op_pkg::store_req_t  store_req,
  input  logic                    store_valid,
  output logic                    store_ready,
  output logic                    store_rsp_valid,
  input  logic                    store_rsp_ready,
  output axi_pkg::axi_rd_req_t    rd_req,
  input  axi_pkg::axi_rd_rsp_t    rd_rsp,
  output axi_pkg::axi_wr_req_t    wr_req,
  input  axi_pkg::axi_wr_rsp_t    wr_rsp
);

  // load side state, captured on the AR transfer
  logic [2:0]           ld_off_q;
  lsu_op_pkg::ld_func_e ld_func_q;
  logic [63:0]          rd_shifted;

  // write channels still to send for the current store
  logic aw_pending;
  logic w_pending;

  logic [63:0] st_data_aligned;
  logic [7:0]  st_mask;

  always_comb begin
    rd_req.ar.addr = load_req.addr;
    case (load_req.func)
      lsu_op_pkg::LD_B, lsu_op_pkg::LD_BU: rd_req.ar.size = axi_pkg::AXI_SIZE_B;
      lsu_op_pkg::LD_H, lsu_op_pkg::LD_HU: rd_req.ar.size = axi_pkg::AXI_SIZE_H;
      default:                             rd_req.ar.size = axi_pkg::AXI_SIZE_W;
    endcase
    rd_req.arvalid = load_valid;
    rd_req.rready  = load_rsp_ready;
  end

  assign load_ready     = rd_rsp.arready;
  assign load_rsp_valid = rd_rsp.rvalid;

  always_ff @(posedge clk) begin
    if (load_valid && load_ready) begin
      ld_off_q  <= load_req.addr[2:0];
      ld_func_q <= load_req.func;
    end
  end

  // bring the addressed byte down to lane 0
  assign rd_shifted = rd_rsp.r.data >> {ld_off_q, 3'b000};

  always_comb begin
    case (ld_func_q)
      lsu_op_pkg::LD_B:  load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
      lsu_op_pkg::LD_BU: load_data = {24'b0, rd_shifted[7:0]};
      lsu_op_pkg::LD_H:  load_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
      lsu_op_pkg::LD_HU: load_data = {16'b0, rd_shifted[15:0]};
      default:           load_data = rd_shifted[31:0];
    endcase
  end

  // store alignment into the 64-bit lane
  always_comb begin
    case (store_req.func)
      lsu_op_pkg::ST_B: st_mask = 8'b0000_0001;
      lsu_op_pkg::ST_H: st_mask = 8'b0000_0011;
      default:          st_mask = 8'b0000_1111;
    endcase
  end

  assign st_data_aligned = {32'b0, store_req.data} << {store_req.addr[2:0], 3'b000};

  always_comb begin
    wr_req.aw.addr = store_req.addr;
    case (store_req.func)
      lsu_op_pkg::ST_B: wr_req.aw.size = axi_pkg::AXI_SIZE_B;
      lsu_op_pkg::ST_H: wr_req.aw.size = axi_pkg::AXI_SIZE_H;
      default:          wr_req.aw.size = axi_pkg::AXI_SIZE_W;
    endcase
    wr_req.awvalid = store_valid && aw_pending;
    wr_req.w.data  = st_data_aligned;
    wr_req.w.strb  = st_mask << store_req.addr[2:0];
    wr_req.w.last  = 1'b1;
    wr_req.wvalid  = store_valid && w_pending;
    wr_req.bready  = store_rsp_ready;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_pending <= 1'b1;
      w_pending  <= 1'b1;
    end else if (wr_rsp.bvalid && wr_req.bready) begin
      aw_pending <= 1'b1;
      w_pending  <= 1'b1;
    end else begin
      if (wr_req.awvalid && wr_rsp.awready) begin
        aw_pending <= 1'b0;
      end
      if (wr_req.wvalid && wr_rsp.wready) begin
        w_pending <= 1'b0;
      end
    end
  end

  // done once each channel is either taken now or already gone
  assign store_ready = (wr_rsp.awready || !aw_pending) && (wr_rsp.wready || !w_pending);
  assign store_rsp_valid = wr_rsp.bvalid;

  a_load_aligned: assert property (@(posedge clk) disable iff (!rstn)
    load_valid |-> (rd_req.ar.size != axi_pkg::AXI_SIZE_H || !load_req.addr[0]) &&
                   (rd_req.ar.size != axi_pkg::AXI_SIZE_W || load_req.addr[1:0] == 2'b00));

  a_store_aligned: assert property (@(posedge clk) disable iff (!rstn)
    store_valid |-> (wr_req.aw.size != axi_pkg::AXI_SIZE_H || !store_req.addr[0]) &&
                    (wr_req.aw.size != axi_pkg::AXI_SIZE_W || store_req.addr[1:0] == 2'b00));

  a_load_req_stable: assert property (@(posedge clk) disable iff (!rstn)
    load_valid && !load_ready |=> $stable(load_req));

endmodule

//--- hw/axi_ram.sv
`timescale 1ns/1ps

module axi_ram #(
  parameter int unsigned RAM_WORDS    = 256,
  parameter int unsigned READ_LATENCY = 3
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  axi_pkg::axi_rd_req_t  rd_req,
  output axi_pkg::axi_rd_rsp_t  rd_rsp,
  input  axi_pkg::axi_wr_req_t  wr_req,
  output axi_pkg::axi_wr_rsp_t  wr_rsp
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = $clog2(READ_LATENCY + 1);

  logic [63:0] mem [RAM_WORDS];

  // read path
  logic             rd_busy;
  logic             rd_valid;
  logic [CNT_W-1:0] rd_cnt;
  logic [31:0]      rd_addr_q;
  logic [63:0]      rd_data_q;

  // write path holding registers
  logic        aw_held;
  logic        w_held;
  logic        b_valid;
  logic [31:0] wr_addr_q;
  logic [63:0] wr_data_q;
  logic [7:0]  wr_strb_q;

  // doubleword index, wraps at the memory depth
  function automatic logic [IDX_W-1:0] word_idx(input logic [31:0] addr);
    logic [31:0] w;
    w = {3'b000, addr[31:3]} % RAM_WORDS;
    return w[IDX_W-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_busy  <= 1'b0;
      rd_valid <= 1'b0;
      rd_cnt   <= '0;
    end else if (!rd_busy) begin
      if (rd_req.arvalid) begin
        rd_busy <= 1'b1;
        rd_cnt  <= CNT_W'(READ_LATENCY - 1);
      end
    end else if (rd_valid) begin
      if (rd_req.rready) begin
        rd_busy  <= 1'b0;
        rd_valid <= 1'b0;
      end
    end else if (rd_cnt == '0) begin
      rd_valid <= 1'b1;
    end else begin
      rd_cnt <= rd_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rd_busy && rd_req.arvalid) begin
      rd_addr_q <= rd_req.ar.addr;
    end
    if (rd_busy && !rd_valid && rd_cnt == '0) begin
      rd_data_q <= mem[word_idx(rd_addr_q)];
    end
  end

  always_comb begin
    rd_rsp.arready = !rd_busy;
    rd_rsp.rvalid  = rd_valid;
    rd_rsp.r.data  = rd_data_q;
    rd_rsp.r.resp  = axi_pkg::AXI_RESP_OKAY;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      b_valid <= 1'b0;
    end else if (b_valid) begin
      if (wr_req.bready) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
        b_valid <= 1'b0;
      end
    end else begin
      if (!aw_held && wr_req.awvalid) begin
        aw_held <= 1'b1;
      end
      if (!w_held && wr_req.wvalid) begin
        w_held <= 1'b1;
      end
      if (aw_held && w_held) begin
        b_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!aw_held && wr_req.awvalid) begin
      wr_addr_q <= wr_req.aw.addr;
    end
    if (!w_held && wr_req.wvalid) begin
      wr_data_q <= wr_req.w.data;
      wr_strb_q <= wr_req.w.strb;
    end
    // commit strobed bytes once, as bvalid rises
    if (aw_held && w_held && !b_valid) begin
      for (int i = 0; i < 8; i++) begin
        if (wr_strb_q[i]) begin
          mem[word_idx(wr_addr_q)][i*8 +: 8] <= wr_data_q[i*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    wr_rsp.awready = !aw_held;
    wr_rsp.wready  = !w_held;
    wr_rsp.bvalid  = b_valid;
    wr_rsp.b.resp  = axi_pkg::AXI_RESP_OKAY;
  end

  a_r_stable: assert property (@(posedge clk) disable iff (!rstn)
    rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.r.data));

  a_b_held: assert property (@(posedge clk) disable iff (!rstn)
    wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid);

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned RAM_WORDS    = 256,
  parameter int unsigned READ_LATENCY = 3
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  lsu_op_pkg::load_req_t   load_req,
  input  logic                    load_valid,
  output logic                    load_ready,
  output logic [31:0]             load_data,
  output logic                    load_rsp_valid,
  input  logic                    load_rsp_ready,
  input  lsu_op_pkg::store_req_t  store_req,
  input  logic                    store_valid,
  output logic                    store_ready,
  output logic                    store_rsp_valid,
  input  logic                    store_rsp_ready
);

  // bus between the unit and the memory
  axi_pkg::axi_rd_req_t rd_req;
  axi_pkg::axi_rd_rsp_t rd_rsp;
  axi_pkg::axi_wr_req_t wr_req;
  axi_pkg::axi_wr_rsp_t wr_rsp;

  lsu u_lsu (
    .clk             (clk),
    .rstn            (rstn),
    .load_req        (load_req),
    .load_valid      (load_valid),
    .load_ready      (load_ready),
    .load_data       (load_data),
    .load_rsp_valid  (load_rsp_valid),
    .load_rsp_ready  (load_rsp_ready),
    .store_req       (store_req),
    .store_valid     (store_valid),
    .store_ready     (store_ready),
    .store_rsp_valid (store_rsp_valid),
    .store_rsp_ready (store_rsp_ready),
    .rd_req          (rd_req),
    .rd_rsp          (rd_rsp),
    .wr_req          (wr_req),
    .wr_rsp          (wr_rsp)
  );

  axi_ram #(
    .RAM_WORDS    (RAM_WORDS),
    .READ_LATENCY (READ_LATENCY)
  ) u_ram (
    .clk    (clk),
    .rstn   (rstn),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .wr_req (wr_req),
    .wr_rsp (wr_rsp)
  );

endmodule

//--- testbench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  localparam int    READ_LATENCY = 3;
  localparam int    RAM_WORDS    = 256;
  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 16;
  localparam string STIM_FILE    = "testbench/lsu_stimulus.txt";

  logic                   clk;
  logic                   rstn;
  lsu_op_pkg::load_req_t  load_req;
  logic                   load_valid;
  logic                   load_ready;
  logic [31:0]            load_data;
  logic                   load_rsp_valid;
  logic                   load_rsp_ready;
  lsu_op_pkg::store_req_t store_req;
  logic                   store_valid;
  logic                   store_ready;
  logic                   store_rsp_valid;
  logic                   store_rsp_ready;

  // stimulus columns with one entry per operation
  logic [7:0]  op_q[$];
  logic [2:0]  func_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] sdata_q[$];
  logic [31:0] exp_q[$];
  int          n_ops;
  bit          stim_loaded;
  int          errors;

  lsu_top #(
    .RAM_WORDS    (RAM_WORDS),
    .READ_LATENCY (READ_LATENCY)
  ) dut0 (
    .clk             (clk),
    .rstn            (rstn),
    .load_req        (load_req),
    .load_valid      (load_valid),
    .load_ready      (load_ready),
    .load_data       (load_data),
    .load_rsp_valid  (load_rsp_valid),
    .load_rsp_ready  (load_rsp_ready),
    .store_req       (store_req),
    .store_valid     (store_valid),
    .store_ready     (store_ready),
    .store_rsp_valid (store_rsp_valid),
    .store_rsp_ready (store_rsp_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("CHECK FAILED %s expected %0h got %0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic read_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] f;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank lines and the column header
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h %h", op, f, a, d, e);
      if (n != 5) begin
        $display("stimulus line could not be parsed: %s", line);
        errors++;
        continue;
      end
      op_q.push_back(op);
      func_q.push_back(f[2:0]);
      addr_q.push_back(a);
      sdata_q.push_back(d);
      exp_q.push_back(e);
    end
    $fclose(fd);
  endtask

  task automatic do_load(input logic [2:0] func, input logic [31:0] addr,
                         input logic [31:0] exp);
    int edges;
    int hold;
    load_req.addr <= addr;
    load_req.func <= lsu_op_pkg::ld_func_e'(func);
    load_valid    <= 1'b1;
    do @(posedge clk); while (!load_ready);
    load_valid <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      // a read is pending, so no new load may be taken
      check_eq("load_ready", 1'b0, load_ready);
    end while (!load_rsp_valid);
    // rvalid rises on the latency edge and is first seen one edge later
    assert (edges - 1 == READ_LATENCY) else begin
      $display("load response came %0d cycles after acceptance instead of %0d",
               edges - 1, READ_LATENCY);
      errors++;
    end
    check_eq("load_data", exp, load_data);
    hold = $urandom_range(3, 0);
    repeat (hold) begin
      @(posedge clk);
      check_eq("load_rsp_valid", 1'b1, load_rsp_valid);
      check_eq("load_data", exp, load_data);
      check_eq("load_ready", 1'b0, load_ready);
    end
    load_rsp_ready <= 1'b1;
    @(posedge clk);
    check_eq("load_rsp_valid", 1'b1, load_rsp_valid);
    load_rsp_ready <= 1'b0;
  endtask

  task automatic do_store(input logic [2:0] func, input logic [31:0] addr,
                          input logic [31:0] data);
    int edges;
    int hold;
    store_req.addr <= addr;
    store_req.data <= data;
    store_req.func <= lsu_op_pkg::st_func_e'(func);
    store_valid    <= 1'b1;
    do @(posedge clk); while (!store_ready);
    store_valid <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
    end while (!store_rsp_valid);
    // AW and W go together, so the response follows one cycle later
    assert (edges - 1 == 1) else begin
      $display("store response came %0d cycles after acceptance instead of 1", edges - 1);
      errors++;
    end
    hold = $urandom_range(3, 0);
    repeat (hold) begin
      @(posedge clk);
      check_eq("store_rsp_valid", 1'b1, store_rsp_valid);
      // both write channels are done and no read is pending
      check_eq("store_ready", 1'b1, store_ready);
      check_eq("load_ready", 1'b1, load_ready);
    end
    store_rsp_ready <= 1'b1;
    @(posedge clk);
    check_eq("store_rsp_valid", 1'b1, store_rsp_valid);
    store_rsp_ready <= 1'b0;
  endtask

  initial begin : main
    int errs_before;
    int pass_cnt;
    int fail_cnt;
    clk             = 1'b0;
    rstn            = 1'b0;
    load_req        = '0;
    load_valid      = 1'b0;
    load_rsp_ready  = 1'b0;
    store_req       = '0;
    store_valid     = 1'b0;
    store_rsp_ready = 1'b0;
    errors          = 0;
    pass_cnt        = 0;
    fail_cnt        = 0;
    void'($urandom(59426));
    read_stimulus();
    n_ops       = op_q.size();
    stim_loaded = 1'b1;
    if (n_ops == 0) begin
      $display("no operations were read from the stimulus file");
      errors++;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      errs_before = errors;
      check_eq("load_rsp_valid", 1'b0, load_rsp_valid);
      check_eq("store_rsp_valid", 1'b0, store_rsp_valid);
      check_eq("load_ready", 1'b1, load_ready);
      check_eq("store_ready", 1'b1, store_ready);
      if (errors == errs_before) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("test reset: %s", (errors == errs_before) ? "ok" : "FAILED");
      for (int i = 0; i < n_ops; i++) begin
        errs_before = errors;
        if (op_q[i] == "S") begin
          do_store(func_q[i], addr_q[i], sdata_q[i]);
        end else if (op_q[i] == "L") begin
          do_load(func_q[i], addr_q[i], exp_q[i]);
        end else begin
          $display("unknown operation letter %c in stimulus line %0d", op_q[i], i);
          errors++;
        end
        if (errors == errs_before) begin
          pass_cnt++;
        end else begin
          fail_cnt++;
        end
        $display("test %0d: %c func %0d addr %08h %s", i, op_q[i], func_q[i], addr_q[i],
                 (errors == errs_before) ? "ok" : "FAILED");
      end
    end
    $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // limit scales with the number of operations
  initial begin : watchdog
    longint limit_ns;
    wait (stim_loaded);
    limit_ns = longint'(n_ops) * (READ_LATENCY + 10) * CLK_PERIOD
             + longint'(RESET_CYCLES + 2) * CLK_PERIOD;
    #(limit_ns);
    $display("timeout after %0d ns, a handshake never completed", limit_ns);
    $display("Something failed");
    $finish;
  end

endmodule

//--- testbench/lsu_stimulus.txt
# op func addr store_data expected_load, all hex
# S func 0 SB, 1 SH, 2 SW; L func 0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU
S 2 00000100 81f27a93 00000000
S 2 00000104 c46e5bd7 00000000
L 2 00000100 00000000 81f27a93
L 2 00000104 00000000 c46e5bd7
L 0 00000100 00000000 ffffff93
L 4 00000100 00000000 00000093
L 0 00000101 00000000 0000007a
L 4 00000101 00000000 0000007a
L 0 00000102 00000000 fffffff2
L 4 00000102 00000000 000000f2
L 0 00000103 00000000 ffffff81
L 4 00000103 00000000 00000081
L 0 00000104 00000000 ffffffd7
L 4 00000104 00000000 000000d7
L 0 00000105 00000000 0000005b
L 4 00000105 00000000 0000005b
L 0 00000106 00000000 0000006e
L 4 00000106 00000000 0000006e
L 0 00000107 00000000 ffffffc4
L 4 00000107 00000000 000000c4
L 1 00000100 00000000 00007a93
L 5 00000100 00000000 00007a93
L 1 00000102 00000000 ffff81f2
L 5 00000102 00000000 000081f2
L 1 00000104 00000000 00005bd7
L 5 00000104 00000000 00005bd7
L 1 00000106 00000000 ffffc46e
L 5 00000106 00000000 0000c46e
S 2 00000108 01234567 00000000
S 2 0000010c 89abcdef 00000000
S 0 00000109 123456a5 00000000
S 1 0000010e dead3c5e 00000000
L 2 00000108 00000000 0123a567
L 2 0000010c 00000000 3c5ecdef

//--- sources.f
hw/lsu_op_pkg.sv
hw/axi_pkg.sv
hw/lsu.sv
hw/axi_ram.sv
hw/lsu_top.sv
testbench/tb_lsu.sv

//--- Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Everything OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
